// ==== common/rvPkg.sv ====
package rvPkg;

    localparam int XLEN       = 32;
    localparam int RegNameW   = 5;
    localparam int QueueDepth = 8;
    localparam int QueuePtrW  = 3;    // Pointers wrap, so depth is 2**QueuePtrW

    localparam logic [XLEN-1:0] ResetPc = '0;

    // RV32I major opcodes
    localparam logic [6:0] OpLui    = 7'b0110111;
    localparam logic [6:0] OpAuipc  = 7'b0010111;
    localparam logic [6:0] OpJal    = 7'b1101111;
    localparam logic [6:0] OpJalr   = 7'b1100111;
    localparam logic [6:0] OpBranch = 7'b1100011;
    localparam logic [6:0] OpLoad   = 7'b0000011;
    localparam logic [6:0] OpStore  = 7'b0100011;
    localparam logic [6:0] OpImm    = 7'b0010011;
    localparam logic [6:0] OpReg    = 7'b0110011;

    typedef enum logic [5:0] {
        NOP,
        LUI, AUIPC,
        JAL, JALR,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        LB, LH, LW, LBU, LHU,
        SB, SH, SW,
        ADDI, SLTI, SLTIU, XORI, ORI, ANDI,
        SLLI, SRLI, SRAI,
        ADD, SUB, SLL, SLT, SLTU,
        XOR, SRL, SRA, OR, AND
    } rvOpT;

    // Immediate formats used by both the fetch predictor and the decoder
    function automatic logic [XLEN-1:0] immU(input logic [XLEN-1:0] inst);
        return {inst[31:12], 12'b0};
    endfunction

    function automatic logic [XLEN-1:0] immJ(input logic [XLEN-1:0] inst);
        return {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    endfunction

    function automatic logic [XLEN-1:0] immB(input logic [XLEN-1:0] inst);
        return {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    endfunction

    function automatic logic [XLEN-1:0] immI(input logic [XLEN-1:0] inst);
        return {{21{inst[31]}}, inst[30:20]};
    endfunction

    function automatic logic [XLEN-1:0] immS(input logic [XLEN-1:0] inst);
        return {{21{inst[31]}}, inst[30:25], inst[11:7]};
    endfunction

endpackage

// ==== rtl/fetch/fetchUnit.sv ====
`timescale 1ns/100ps

module fetchUnit import rvPkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            flush,
    input  logic [XLEN-1:0] flushPc,
    input  logic            memValid,
    input  logic [XLEN-1:0] memData,
    input  logic            almostFull,
    output logic            memReq,
    output logic [XLEN-1:0] memAddr,
    output logic            push,
    output logic [XLEN-1:0] pushInst,
    output logic [XLEN-1:0] pushPc,
    output logic            pushPd
);

    logic [XLEN-1:0] pc;
    logic            pending;
    logic            discard;
    logic            started;
    logic            respOk;
    logic [6:0]      opcode;
    logic [XLEN-1:0] jImm;
    logic [XLEN-1:0] bImm;
    logic            predTaken;
    logic [XLEN-1:0] predPc;

    assign opcode = memData[6:0];
    assign jImm   = immJ(memData);
    assign bImm   = immB(memData);
    assign respOk = memValid && !discard && !flush;    // Stale or flushed responses die here

    // Static prediction takes JAL and backward branches
    always_comb begin
        predTaken = 1'b0;
        predPc    = pc + XLEN'(4);
        if (opcode == OpJal) begin
            predTaken = 1'b1;
            predPc    = pc + jImm;
        end else if (opcode == OpBranch && bImm[XLEN-1]) begin
            predTaken = 1'b1;
            predPc    = pc + bImm;
        end
    end

    assign memAddr = pc;
    assign memReq  = started && !pending && !almostFull && !push && !flush;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= ResetPc;
            started <= 1'b0;
            pending <= 1'b0;
            discard <= 1'b0;
            push    <= 1'b0;
        end else begin
            started <= 1'b1;
            push    <= respOk;
            if (memReq) begin
                pending <= 1'b1;
            end else if (memValid) begin
                pending <= 1'b0;
            end
            if (memValid) begin
                discard <= 1'b0;
            end else if (flush && pending) begin
                discard <= 1'b1;    // Response still in flight
            end
            if (flush) begin
                pc <= flushPc;
            end else if (respOk) begin
                pc <= predPc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (respOk) begin
            pushInst <= memData;
            pushPc   <= pc;
            pushPd   <= predTaken;
        end
    end

    // Memory may only answer an outstanding request
    respOnlyWhenPending: assert property (@(posedge clk) disable iff (rst)
        memValid |-> pending)
        else $error("memValid without a pending request");

endmodule

// ==== rtl/instQueue.sv ====
`timescale 1ns/100ps

module instQueue import rvPkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            flush,
    input  logic            push,
    input  logic [XLEN-1:0] pushInst,
    input  logic [XLEN-1:0] pushPc,
    input  logic            pushPd,
    input  logic            pop,
    output logic [XLEN-1:0] headInst,
    output logic [XLEN-1:0] headPc,
    output logic            headPd,
    output logic            empty,
    output logic            almostFull
);

    logic [XLEN-1:0]      instMem [QueueDepth];
    logic [XLEN-1:0]      pcMem   [QueueDepth];
    logic                 pdMem   [QueueDepth];
    logic [QueuePtrW-1:0] wrPtr;
    logic [QueuePtrW-1:0] rdPtr;
    logic [QueuePtrW:0]   count;

    assign headInst   = instMem[rdPtr];
    assign headPc     = pcMem[rdPtr];
    assign headPd     = pdMem[rdPtr];
    assign empty      = (count == '0);
    assign almostFull = (count >= (QueuePtrW+1)'(QueueDepth - 1));    // One slot or less

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push && !flush) begin
            instMem[wrPtr] <= pushInst;
            pcMem[wrPtr]   <= pushPc;
            pdMem[wrPtr]   <= pushPd;
        end
    end

    noPushWhenFull: assert property (@(posedge clk) disable iff (rst || flush)
        push |-> count != (QueuePtrW+1)'(QueueDepth))
        else $error("Push into a full queue");

    noPopWhenEmpty: assert property (@(posedge clk) disable iff (rst || flush)
        pop |-> !empty)
        else $error("Pop from an empty queue");

endmodule

// ==== rtl/decode/instDecoder.sv ====
`timescale 1ns/100ps

module instDecoder import rvPkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                rdy,
    input  logic                flush,
    input  logic [XLEN-1:0]     headInst,
    input  logic [XLEN-1:0]     headPc,
    input  logic                headPd,
    input  logic                empty,
    output logic                pop,
    output logic                decEn,
    output logic [RegNameW-1:0] rs1,
    output logic [RegNameW-1:0] rs2,
    output logic [RegNameW-1:0] rd,
    output rvOpT                op,
    output logic [XLEN-1:0]     pc,
    output logic [XLEN-1:0]     imm,
    output logic                pd
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [3:0]      funct;
    logic [XLEN-1:0] decImm;
    rvOpT            decOp;

    assign opcode = headInst[6:0];
    assign funct3 = headInst[14:12];
    assign funct  = {headInst[30], funct3};    // Bit 30 splits ADD/SUB and SRL/SRA

    assign pop = rdy && !empty && !flush;

    always_comb begin
        case (opcode)
            OpLui, OpAuipc:         decImm = immU(headInst);
            OpJal:                  decImm = immJ(headInst);
            OpBranch:               decImm = immB(headInst);
            OpJalr, OpLoad, OpImm:  decImm = immI(headInst);
            OpStore:                decImm = immS(headInst);
            default:                decImm = '0;
        endcase
    end

    always_comb begin
        decOp = NOP;
        case (opcode)
            OpLui:   decOp = LUI;
            OpAuipc: decOp = AUIPC;
            OpJal:   decOp = JAL;
            OpJalr:  decOp = JALR;
            OpBranch: begin
                case (funct3)
                    3'b000:  decOp = BEQ;
                    3'b001:  decOp = BNE;
                    3'b100:  decOp = BLT;
                    3'b101:  decOp = BGE;
                    3'b110:  decOp = BLTU;
                    3'b111:  decOp = BGEU;
                    default: decOp = NOP;
                endcase
            end
            OpLoad: begin
                case (funct3)
                    3'b000:  decOp = LB;
                    3'b001:  decOp = LH;
                    3'b010:  decOp = LW;
                    3'b100:  decOp = LBU;
                    3'b101:  decOp = LHU;
                    default: decOp = NOP;
                endcase
            end
            OpStore: begin
                case (funct3)
                    3'b000:  decOp = SB;
                    3'b001:  decOp = SH;
                    3'b010:  decOp = SW;
                    default: decOp = NOP;
                endcase
            end
            OpImm: begin
                // Bit 30 is immediate data except for shifts
                case (funct3)
                    3'b000:  decOp = ADDI;
                    3'b010:  decOp = SLTI;
                    3'b011:  decOp = SLTIU;
                    3'b100:  decOp = XORI;
                    3'b110:  decOp = ORI;
                    3'b111:  decOp = ANDI;
                    3'b001:  decOp = SLLI;
                    default: decOp = headInst[30] ? SRAI : SRLI;
                endcase
            end
            OpReg: begin
                case (funct)
                    4'b0000: decOp = ADD;
                    4'b1000: decOp = SUB;
                    4'b0001: decOp = SLL;
                    4'b0010: decOp = SLT;
                    4'b0011: decOp = SLTU;
                    4'b0100: decOp = XOR;
                    4'b0101: decOp = SRL;
                    4'b1101: decOp = SRA;
                    4'b0110: decOp = OR;
                    4'b0111: decOp = AND;
                    default: decOp = NOP;
                endcase
            end
            default: decOp = NOP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            decEn <= 1'b0;
        end else begin
            decEn <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            rs1 <= headInst[19:15];
            rs2 <= headInst[24:20];
            rd  <= headInst[11:7];
            op  <= decOp;
            pc  <= headPc;
            imm <= decImm;
            pd  <= headPd;
        end
    end

endmodule

// ==== rtl/frontEnd.sv ====
`timescale 1ns/100ps

module frontEnd import rvPkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                rdy,
    input  logic                flush,
    input  logic [XLEN-1:0]     flushPc,
    input  logic                memValid,
    input  logic [XLEN-1:0]     memData,
    output logic                memReq,
    output logic [XLEN-1:0]     memAddr,
    output logic                decEn,
    output logic [RegNameW-1:0] rs1,
    output logic [RegNameW-1:0] rs2,
    output logic [RegNameW-1:0] rd,
    output rvOpT                op,
    output logic [XLEN-1:0]     pc,
    output logic [XLEN-1:0]     imm,
    output logic                pd
);

    logic            push;
    logic [XLEN-1:0] pushInst;
    logic [XLEN-1:0] pushPc;
    logic            pushPd;
    logic            almostFull;
    logic            pop;
    logic [XLEN-1:0] headInst;
    logic [XLEN-1:0] headPc;
    logic            headPd;
    logic            empty;

    fetchUnit fetchUnit_inst (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .flushPc    (flushPc),
        .memValid   (memValid),
        .memData    (memData),
        .almostFull (almostFull),
        .memReq     (memReq),
        .memAddr    (memAddr),
        .push       (push),
        .pushInst   (pushInst),
        .pushPc     (pushPc),
        .pushPd     (pushPd)
    );

    instQueue instQueue_inst (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .push       (push),
        .pushInst   (pushInst),
        .pushPc     (pushPc),
        .pushPd     (pushPd),
        .pop        (pop),
        .headInst   (headInst),
        .headPc     (headPc),
        .headPd     (headPd),
        .empty      (empty),
        .almostFull (almostFull)
    );

    instDecoder instDecoder_inst (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .flush    (flush),
        .headInst (headInst),
        .headPc   (headPc),
        .headPd   (headPd),
        .empty    (empty),
        .pop      (pop),
        .decEn    (decEn),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .op       (op),
        .pc       (pc),
        .imm      (imm),
        .pd       (pd)
    );

endmodule

// ==== tb/instMemModel.sv ====
`timescale 1ns/100ps

module instMemModel import rvPkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            memReq,
    input  logic [XLEN-1:0] memAddr,
    output logic            memValid,
    output logic [XLEN-1:0] memData,
    input  logic [XLEN-1:0] peekAddr,
    output logic [XLEN-1:0] peekWord
);

    localparam logic [31:0] Seed = 32'd8704;

    logic [31:0]     lcg;
    logic            busy;
    logic            respond;
    logic [XLEN-1:0] reqAddr;
    logic [XLEN-1:0] respAddr;
    int              waitCnt;
    int              lat;

    function automatic logic [31:0] nextRand(input logic [31:0] x);
        return x * 32'd1103515245 + 32'd12345;
    endfunction

    // Contents hashed from the full address
    function automatic logic [XLEN-1:0] wordAt(input logic [XLEN-1:0] addr);
        logic [31:0] h;
        logic [6:0]  opc;
        h = (addr ^ 32'h5bd1e995) * 32'h01000193;
        h = h ^ (h >> 15);
        h = h * 32'h2c1b3c6d;
        h = h ^ (h >> 13);
        case (h[3:0])
            4'd0:               opc = OpLui;
            4'd1:               opc = OpAuipc;
            4'd2:               opc = OpJal;
            4'd3:               opc = OpJalr;
            4'd4, 4'd5:         opc = OpBranch;
            4'd6:               opc = OpLoad;
            4'd7:               opc = OpStore;
            4'd11, 4'd12:       opc = OpReg;
            4'd13:              opc = 7'b1111111;    // Illegal
            default:            opc = OpImm;
        endcase
        if (opc == OpReg) begin
            return {1'b0, h[30], 5'b0, h[24:7], opc};    // funct7 0 or 0x20
        end
        return {h[31:7], opc};
    endfunction

    assign peekWord = wordAt(peekAddr);

    initial begin
        memValid = 1'b0;
        memData  = '0;
        busy     = 1'b0;
        lcg      = Seed;
        reqAddr  = '0;
        waitCnt  = 0;
        forever begin
            @(posedge clk);
            respond  = 1'b0;
            respAddr = reqAddr;
            if (rst) begin
                busy = 1'b0;
                lcg  = Seed;
            end else if (busy) begin
                if (waitCnt == 1) begin
                    respond = 1'b1;
                    busy    = 1'b0;
                end else begin
                    waitCnt = waitCnt - 1;
                end
            end else if (memReq) begin
                lat      = 1 + int'((lcg >> 16) % 32'd3);    // 1 to 3 cycles
                lcg      = nextRand(lcg);
                reqAddr  = memAddr;
                respAddr = memAddr;
                if (lat == 1) begin
                    respond = 1'b1;
                end else begin
                    busy    = 1'b1;
                    waitCnt = lat - 1;
                end
            end
            #1;
            memValid = respond;
            if (respond) begin
                memData = wordAt(respAddr);
            end
        end
    end

endmodule

// ==== tb/frontEndTb.sv ====
`timescale 1ns/100ps

module frontEndTb import rvPkg::*; ();

    localparam int RunCycles      = 1500;
    localparam int WatchdogCycles = 2 * RunCycles + 1000;

    logic                clk = 1'b0;
    logic                rst;
    logic                rdy;
    logic                flush;
    logic [XLEN-1:0]     flushPc;
    logic                memValid;
    logic [XLEN-1:0]     memData;
    logic                memReq;
    logic [XLEN-1:0]     memAddr;
    logic                decEn;
    logic [RegNameW-1:0] rs1;
    logic [RegNameW-1:0] rs2;
    logic [RegNameW-1:0] rd;
    rvOpT                op;
    logic [XLEN-1:0]     pc;
    logic [XLEN-1:0]     imm;
    logic                pd;

    logic [XLEN-1:0]     expPc;
    logic [XLEN-1:0]     refWord;    // Word at the expected pc
    logic [31:0]         seed;
    int                  errors;
    int                  decCount;
    int                  cycle;
    int                  waitCycles;

    frontEnd frontEnd_inst (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .flush    (flush),
        .flushPc  (flushPc),
        .memValid (memValid),
        .memData  (memData),
        .memReq   (memReq),
        .memAddr  (memAddr),
        .decEn    (decEn),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .op       (op),
        .pc       (pc),
        .imm      (imm),
        .pd       (pd)
    );

    instMemModel instMemModel_inst (
        .clk      (clk),
        .rst      (rst),
        .memReq   (memReq),
        .memAddr  (memAddr),
        .memValid (memValid),
        .memData  (memData),
        .peekAddr (expPc),
        .peekWord (refWord)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] nextRand(input logic [31:0] x);
        return x * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] refImm(input logic [31:0] w);
        logic [31:0] iImm;
        iImm = $signed(w) >>> 20;
        case (w[6:0])
            OpLui, OpAuipc:        return {w[31:12], 12'h000};
            OpJal:                 return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            OpBranch:              return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            OpJalr, OpLoad, OpImm: return iImm;
            OpStore:               return {iImm[31:5], w[11:7]};
            default:               return '0;
        endcase
    endfunction

    function automatic rvOpT refOp(input logic [31:0] w);
        logic [2:0] f3;
        f3 = w[14:12];
        case (w[6:0])
            OpLui:    return LUI;
            OpAuipc:  return AUIPC;
            OpJal:    return JAL;
            OpJalr:   return JALR;
            OpBranch: begin
                if (f3 == 3'd0) return BEQ;
                if (f3 == 3'd1) return BNE;
                if (f3 == 3'd4) return BLT;
                if (f3 == 3'd5) return BGE;
                if (f3 == 3'd6) return BLTU;
                if (f3 == 3'd7) return BGEU;
            end
            OpLoad: begin
                if (f3 == 3'd0) return LB;
                if (f3 == 3'd1) return LH;
                if (f3 == 3'd2) return LW;
                if (f3 == 3'd4) return LBU;
                if (f3 == 3'd5) return LHU;
            end
            OpStore: begin
                if (f3 == 3'd0) return SB;
                if (f3 == 3'd1) return SH;
                if (f3 == 3'd2) return SW;
            end
            OpImm: begin
                if (f3 == 3'd0) return ADDI;
                if (f3 == 3'd1) return SLLI;
                if (f3 == 3'd2) return SLTI;
                if (f3 == 3'd3) return SLTIU;
                if (f3 == 3'd4) return XORI;
                if (f3 == 3'd5) return w[30] ? SRAI : SRLI;
                if (f3 == 3'd6) return ORI;
                return ANDI;
            end
            OpReg: begin
                if (f3 == 3'd0) return w[30] ? SUB : ADD;
                if (f3 == 3'd5) return w[30] ? SRA : SRL;
                if (w[30]) return NOP;    // Only SUB and SRA use bit 30
                if (f3 == 3'd1) return SLL;
                if (f3 == 3'd2) return SLT;
                if (f3 == 3'd3) return SLTU;
                if (f3 == 3'd4) return XOR;
                if (f3 == 3'd6) return OR;
                return AND;
            end
            default: return NOP;
        endcase
        return NOP;
    endfunction

    function automatic logic takenBit(input logic [31:0] w);
        return (w[6:0] == OpJal) || (w[6:0] == OpBranch && w[31]);
    endfunction

    function automatic logic [31:0] nextPc(input logic [31:0] at, input logic [31:0] w);
        return takenBit(w) ? at + refImm(w) : at + 32'd4;
    endfunction

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] want);
        errors = errors + 1;
        $display("mismatch at %0t: %s got %0h, expected %0h", $time, name, got, want);
    endtask

    task automatic reportFailure(input string what);
        errors = errors + 1;
        $display("Error at %0t: %s", $time, what);
    endtask

    // Expected pc follows the static prediction, restarts at flushPc
    always @(posedge clk) begin
        if (rst) begin
            expPc    <= ResetPc;
            decCount <= 0;
        end else if (flush) begin
            expPc <= flushPc;
        end else if (decEn) begin
            expPc    <= nextPc(expPc, refWord);
            decCount <= decCount + 1;
        end
    end

    resetQuiet: assert property (@(posedge clk) rst |=> !memReq && !decEn)
        else reportFailure("memReq or decEn high during or right after reset");

    pcFollows: assert property (@(posedge clk) disable iff (rst) decEn |-> pc == expPc)
        else reportMismatch("pc", $sampled(pc), $sampled(expPc));

    rs1Field: assert property (@(posedge clk) disable iff (rst) decEn |-> rs1 == refWord[19:15])
        else reportMismatch("rs1", 32'($sampled(rs1)), 32'($sampled(refWord[19:15])));

    rs2Field: assert property (@(posedge clk) disable iff (rst) decEn |-> rs2 == refWord[24:20])
        else reportMismatch("rs2", 32'($sampled(rs2)), 32'($sampled(refWord[24:20])));

    rdField: assert property (@(posedge clk) disable iff (rst) decEn |-> rd == refWord[11:7])
        else reportMismatch("rd", 32'($sampled(rd)), 32'($sampled(refWord[11:7])));

    immValue: assert property (@(posedge clk) disable iff (rst) decEn |-> imm == refImm(refWord))
        else reportMismatch("imm", $sampled(imm), refImm($sampled(refWord)));

    opValue: assert property (@(posedge clk) disable iff (rst) decEn |-> op == refOp(refWord))
        else reportMismatch("op", 32'($sampled(op)), 32'(refOp($sampled(refWord))));

    pdValue: assert property (@(posedge clk) disable iff (rst) decEn |-> pd == takenBit(refWord))
        else reportMismatch("pd", 32'($sampled(pd)), 32'(takenBit($sampled(refWord))));

    flushQuiet: assert property (@(posedge clk) disable iff (rst) flush |=> !decEn)
        else reportFailure("decEn high in the cycle after a flush");

    pauseQuiet: assert property (@(posedge clk) disable iff (rst) !rdy |=> !decEn)
        else reportFailure("decEn high in the cycle after rdy was low");

    initial begin
        repeat (WatchdogCycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles", WatchdogCycles);
        $display("Test failed");
        $finish;
    end

    initial begin
        rst     = 1'b1;
        rdy     = 1'b0;
        flush   = 1'b0;
        flushPc = '0;
        seed    = 32'd8704;
        errors  = 0;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
        for (cycle = 0; cycle < RunCycles; cycle++) begin
            @(posedge clk);
            #1;
            seed  = nextRand(seed);
            rdy   = (seed[29:28] != 2'b00);    // Roughly 3 of 4 cycles
            flush = (cycle % 400 == 399);
            if (flush) begin
                flushPc = {14'b0, seed[31:16], 2'b00};
            end
        end
        @(posedge clk);
        #1;
        rdy   = 1'b1;
        flush = 1'b0;
        waitCycles = 0;
        while (!decEn && waitCycles < 50) begin
            @(posedge clk);
            #1;
            waitCycles++;
        end
        if (!decEn) begin
            reportFailure("no instruction decoded after the last pause");
        end
        if (decCount < RunCycles / 8) begin
            reportFailure("too few instructions decoded");
        end
        $display("Errors: %0d, instructions decoded: %0d", errors, decCount);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
common/rvPkg.sv
rtl/fetch/fetchUnit.sv
rtl/instQueue.sv
rtl/decode/instDecoder.sv
rtl/frontEnd.sv
tb/instMemModel.sv
tb/frontEndTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f files.f --top-module frontEndTb -o frontEndSim

if ! ./obj_dir/frontEndSim > sim.log 2>&1; then
    cat sim.log
    echo "Simulation exited with an error status"
    exit 1
fi
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
